// ==== common/dmaPkg.sv ====
// shared widths and encodings for the DMA channel, pulled in by a wildcard import in each module
package dmaPkg;

    // word width of the CPU bus and of every FIFO entry
    localparam int DATA_W = 32;

    localparam int ADDR_W = 32; // byte address on the CPU bus

    // CPU-side bus master states
    typedef enum logic [2:0] {
        sIdle,    // waiting for enable and data
        sRequest, // busReq out, waiting for the grant
        sOwn,     // grant taken, busAck driven, address and data settle
        sStrobe,  // address and data strobes asserted until an acknowledge
        sTerm,    // strobes low for one cycle between transfers
        sRelease  // busAck dropped, bus handed back
    } cpuState_t;

    // which part of the head word the bridge puts on the data lines
    typedef enum logic [1:0] {
        laneLong, // whole word on 31:0
        laneHigh, // upper half on 31:16
        laneLow   // lower half moved up to 31:16
    } laneSel_t;

endpackage

// ==== common/fifoIf.sv ====
// FIFO to CPU state machine link, instanced once in the top level and shared by both blocks
`timescale 1ns/1ps

interface fifoIf import dmaPkg::*; #(
    parameter int FIFO_DEPTH = 8
) ();

    // one spare bit so a full FIFO can be told from an empty one
    localparam int CNT_W = $clog2(FIFO_DEPTH) + 1;

    logic              pop;    // removes the head word on the clock edge
    logic [DATA_W-1:0] rdData; // head word, valid whenever empty is low
    logic              empty;
    logic [CNT_W-1:0]  count;  // words currently held

    modport fifo (
        input  pop,
        output rdData, empty, count
    );

    modport sm (
        output pop,
        input  empty, count
    );

endinterface

// ==== common/bridgeIf.sv ====
// control path from the CPU state machine to the address and lane bridge, instanced in the top
`timescale 1ns/1ps

interface bridgeIf import dmaPkg::*; ();

    logic              loadAddr; // copy the start address into the counter
    logic              advance;  // step the counter by the size of the lane
    laneSel_t          lane;

    // head word of the FIFO, wired in by the top level
    logic [DATA_W-1:0] word;

    modport ctrl (
        output loadAddr, advance, lane
    );

    // the bridge only listens
    modport bridge (
        input loadAddr, advance, lane, word
    );

endinterface

// ==== hw/dmaFifo/dmaFifo.sv ====
// word FIFO between the device and the CPU bus, written by device strobes and popped by the FSM
`timescale 1ns/1ps

module dmaFifo import dmaPkg::*; #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic              CLK90,
    input  logic              nRESET,
    input  logic              devWrite,
    input  logic [DATA_W-1:0] devData,
    output logic              fifoFull,
    fifoIf.fifo               fifo
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);
    localparam int CNT_W = PTR_W + 1;

    logic [DATA_W-1:0] mem [FIFO_DEPTH];
    logic [PTR_W-1:0]  wrPtr;
    logic [PTR_W-1:0]  rdPtr;
    logic [CNT_W-1:0]  count;
    logic              doWrite;
    logic              doPop;

    // a strobe while full is lost, the device is expected to watch fifoFull
    assign doWrite = devWrite & ~fifoFull;
    assign doPop   = fifo.pop & ~fifo.empty;

    assign fifoFull    = (count == CNT_W'(FIFO_DEPTH));
    assign fifo.empty  = (count == '0);
    assign fifo.count  = count;
    assign fifo.rdData = mem[rdPtr]; // head is visible without a read cycle

    always_ff @(posedge CLK90) begin
        if (doWrite) begin
            mem[wrPtr] <= devData;
        end
    end

    // pointers wrap on their own since the depth is a power of two
    always_ff @(posedge CLK90 or negedge nRESET) begin
        if (!nRESET) begin
            wrPtr <= '0;
            rdPtr <= '0;
        end else begin
            if (doWrite) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (doPop) begin
                rdPtr <= rdPtr + 1'b1;
            end
        end
    end

    always_ff @(posedge CLK90 or negedge nRESET) begin
        if (!nRESET) begin
            count <= '0;
        end else begin
            case ({doWrite, doPop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count; // both at once leave the fill level alone
            endcase
        end
    end

endmodule

// ==== hw/cpuSm/cpuSm.sv ====
// bus master FSM that owns the CPU bus, runs sized write cycles from the FIFO and signals done
`timescale 1ns/1ps

module cpuSm import dmaPkg::*; (
    input  logic  CLK90,
    input  logic  nRESET,
    input  logic  dmaEna,
    input  logic  flush,
    input  logic  busGrant,
    input  logic  ackLong,
    input  logic  ackWord,
    output logic  busReq,
    output logic  busAck,
    output logic  addrStrobe,
    output logic  dataStrobe,
    output logic  done,
    fifoIf.sm     fifo,
    bridgeIf.ctrl br
);

    cpuState_t state;
    laneSel_t  lane;      // lane of the cycle on the bus, also the port size guess
    laneSel_t  nextLane;
    logic      dmaEnaQ;
    logic      flushPend; // flush seen but not yet answered with done
    logic      flushSeen;
    logic      anyAck;
    logic      wordDone;  // this acknowledge finishes the head word
    logic      moreData;

    assign anyAck    = ackLong | ackWord;
    assign flushSeen = flushPend | flush;

    // the low half always finishes a word, a long acknowledge finishes it from any other lane
    assign wordDone = ackLong | (lane == laneLow);

    // a word acknowledge on a full or high cycle means a 16-bit port took bits 31:16
    always_comb begin
        if (lane == laneLow) begin
            nextLane = laneHigh; // keep using half cycles on this port
        end else if (ackLong) begin
            nextLane = laneLong;
        end else begin
            nextLane = laneLow;
        end
    end

    // in sTerm the pop is still pending, so the last word leaves when count is one
    assign moreData = fifo.pop ? (fifo.count > 1) : !fifo.empty;

    assign br.lane = lane;

    always_ff @(posedge CLK90 or negedge nRESET) begin
        if (!nRESET) begin
            state       <= sIdle;
            lane        <= laneLong;
            dmaEnaQ     <= 1'b0;
            flushPend   <= 1'b0;
            busReq      <= 1'b0;
            busAck      <= 1'b0;
            addrStrobe  <= 1'b0;
            dataStrobe  <= 1'b0;
            done        <= 1'b0;
            fifo.pop    <= 1'b0;
            br.advance  <= 1'b0;
            br.loadAddr <= 1'b0;
        end else begin
            dmaEnaQ     <= dmaEna;
            br.loadAddr <= dmaEna & ~dmaEnaQ; // rising edge of the enable
            fifo.pop    <= 1'b0;
            br.advance  <= 1'b0;
            done        <= 1'b0;
            if (flush) begin
                flushPend <= 1'b1;
            end

            case (state)
                sIdle: begin
                    if (dmaEna && !dmaEnaQ) begin
                        lane <= laneLong; // new transfer, assume a 32-bit port first
                    end
                    if (dmaEna && !fifo.empty) begin
                        state  <= sRequest;
                        busReq <= 1'b1;
                    end else if (flushSeen && fifo.empty) begin
                        done      <= 1'b1; // nothing left to drain
                        flushPend <= 1'b0;
                    end
                end

                sRequest: begin
                    if (busGrant) begin
                        state  <= sOwn;
                        busAck <= 1'b1;
                        busReq <= 1'b0;
                    end
                end

                // address and data settle here before the strobes rise
                sOwn: begin
                    state      <= sStrobe;
                    addrStrobe <= 1'b1;
                    dataStrobe <= 1'b1;
                end

                sStrobe: begin
                    if (anyAck) begin
                        state      <= sTerm;
                        addrStrobe <= 1'b0;
                        dataStrobe <= 1'b0;
                        lane       <= nextLane;
                        fifo.pop   <= wordDone;
                        br.advance <= 1'b1; // step size follows nextLane in the bridge
                    end
                end

                sTerm: begin
                    if (moreData && dmaEna) begin
                        state <= sOwn;
                    end else begin
                        state  <= sRelease;
                        busAck <= 1'b0;
                        if (flushSeen && !moreData) begin
                            done      <= 1'b1;
                            flushPend <= 1'b0;
                        end
                    end
                end

                sRelease: state <= sIdle;

                default: state <= sIdle;
            endcase
        end
    end

endmodule

// ==== hw/busBridge.sv ====
// address counter and data lane steering that put the FSM's write cycles onto the CPU bus
`timescale 1ns/1ps

module busBridge import dmaPkg::*; (
    input  logic              CLK90,
    input  logic              nRESET,
    input  logic [ADDR_W-1:0] startAddr,
    bridgeIf.bridge           br,
    output logic [ADDR_W-1:0] addr,
    output logic [DATA_W-1:0] dataOut
);

    localparam int HALF_W = DATA_W / 2;

    logic [ADDR_W-1:0] step;

    // a full word moves the pointer 4 bytes, a half word 2
    assign step = (br.lane == laneLong) ? ADDR_W'(4) : ADDR_W'(2);

    always_ff @(posedge CLK90 or negedge nRESET) begin
        if (!nRESET) begin
            addr <= '0;
        end else if (br.loadAddr) begin
            addr <= startAddr;
        end else if (br.advance) begin
            addr <= addr + step;
        end
    end

    // 16-bit ports sit on the upper lines, so both halves are sent there
    always_comb begin
        case (br.lane)
            laneHigh: dataOut = {br.word[DATA_W-1 -: HALF_W], {HALF_W{1'b0}}};
            laneLow:  dataOut = {br.word[HALF_W-1:0], {HALF_W{1'b0}}};
            default:  dataOut = br.word;
        endcase
    end

endmodule

// ==== hw/dmaTop.sv ====
// top level of the device-to-memory DMA channel, wiring FIFO, bus FSM and bridge to plain ports
`timescale 1ns/1ps

module dmaTop import dmaPkg::*; #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic              CLK90,
    input  logic              nRESET,
    input  logic              dmaEna,
    input  logic [ADDR_W-1:0] startAddr,
    input  logic              flush,
    input  logic              devWrite,
    input  logic [DATA_W-1:0] devData,
    output logic              fifoFull,
    output logic              busReq,
    input  logic              busGrant,
    output logic              busAck,
    output logic              addrStrobe,
    output logic              dataStrobe,
    output logic [ADDR_W-1:0] addr,
    output logic [DATA_W-1:0] dataOut,
    input  logic              ackLong,
    input  logic              ackWord,
    output logic              done
);

    fifoIf #(.FIFO_DEPTH(FIFO_DEPTH)) fifoBus ();
    bridgeIf brBus ();

    // the bridge steers whatever word sits at the FIFO head
    assign brBus.word = fifoBus.rdData;

    dmaFifo #(.FIFO_DEPTH(FIFO_DEPTH)) fifo0 (
        .CLK90    (CLK90),
        .nRESET   (nRESET),
        .devWrite (devWrite),
        .devData  (devData),
        .fifoFull (fifoFull),
        .fifo     (fifoBus.fifo)
    );

    cpuSm sm0 (
        .CLK90      (CLK90),
        .nRESET     (nRESET),
        .dmaEna     (dmaEna),
        .flush      (flush),
        .busGrant   (busGrant),
        .ackLong    (ackLong),
        .ackWord    (ackWord),
        .busReq     (busReq),
        .busAck     (busAck),
        .addrStrobe (addrStrobe),
        .dataStrobe (dataStrobe),
        .done       (done),
        .fifo       (fifoBus.sm),
        .br         (brBus.ctrl)
    );

    busBridge bridge0 (
        .CLK90     (CLK90),
        .nRESET    (nRESET),
        .startAddr (startAddr),
        .br        (brBus.bridge),
        .addr      (addr),
        .dataOut   (dataOut)
    );

endmodule

// ==== dv/dma_checker.sv ====
// bus and device protocol assertions, bound into the DMA top level by the testbench
`timescale 1ns/1ps

module dma_checker (
    input logic CLK90,
    input logic nRESET,
    input logic addrStrobe,
    input logic busAck,
    input logic ackLong,
    input logic ackWord,
    input logic devWrite,
    input logic fifoFull,
    input logic done
);

    int violations = 0; // assertion failures so far

    // a strobe only ever appears while the channel owns the bus
    strobeOwned: assert property (@(posedge CLK90) disable iff (!nRESET) addrStrobe |-> busAck)
        else begin
            $error("address strobe without bus acknowledge");
            violations++;
        end

    oneAckType: assert property (@(posedge CLK90) disable iff (!nRESET) !(ackLong && ackWord))
        else begin
            $error("long and word acknowledge together");
            violations++;
        end

    // the device side has no back-pressure, so a write into a full FIFO is lost
    noWriteFull: assert property (@(posedge CLK90) disable iff (!nRESET) devWrite |-> !fifoFull)
        else begin
            $error("device write while the FIFO is full");
            violations++;
        end

    donePulse: assert property (@(posedge CLK90) disable iff (!nRESET) done |=> !done)
        else begin
            $error("done held for more than one cycle");
            violations++;
        end

endmodule

// ==== dv/dmaMonitor.sv ====
// watches the DUT bus and compares every acknowledged write against a model of the device words
`timescale 1ns/1ps

module dmaMonitor (
    input  logic        CLK90,
    input  logic        nRESET,
    input  logic        dmaEna,
    input  logic [31:0] startAddr,
    input  logic        devWrite,
    input  logic [31:0] devData,
    input  logic        fifoFull,
    input  logic        busReq,
    input  logic        addrStrobe,
    input  logic        dataStrobe,
    input  logic        ackLong,
    input  logic        ackWord,
    input  logic [31:0] addr,
    input  logic [31:0] dataOut,
    input  logic        done,
    output int          errCount,
    output int          pending,
    output int          reqCount,
    output int          doneCount,
    output int          ackCount
);

    localparam int LANE_LONG = 0;
    localparam int LANE_HIGH = 1; // upper half of the word on 31:16
    localparam int LANE_LOW  = 2;

    logic [31:0] wordQ [$];
    logic [31:0] expAddr;
    logic [31:0] expData;
    logic [31:0] head;
    logic        enaQ;
    logic        reqQ;
    int          lane;
    int          prevPending;
    int          errs, reqs, dones, acks;

    always @(posedge CLK90 or negedge nRESET) begin
        if (!nRESET) begin
            wordQ.delete();
            {enaQ, reqQ} <= '0;
            expAddr = '0;
            lane = LANE_LONG;
            {errs, reqs, dones, acks, prevPending} = '0;
        end else begin
            // both strobes frame every write cycle together
            if (dataStrobe !== addrStrobe) begin
                errs++;
                $display("Fail at %0d ns: dataStrobe expected %b got %b",
                         $time, addrStrobe, dataStrobe);
            end
            if (addrStrobe && (ackLong || ackWord)) begin
                acks++;
                if (wordQ.size() == 0) begin
                    errs++;
                    $display("%0d ns: a write was acknowledged but no device word was left", $time);
                end else begin
                    head = wordQ[0];
                    case (lane)
                        LANE_HIGH: expData = {head[31:16], 16'h0000};
                        LANE_LOW:  expData = {head[15:0], 16'h0000};
                        default:   expData = head;
                    endcase
                    if (addr !== expAddr) begin
                        errs++;
                        $display("Fail at %0d ns: addr expected %h got %h", $time, expAddr, addr);
                    end
                    if (dataOut !== expData) begin
                        errs++;
                        $display("Fail at %0d ns: dataOut expected %h got %h",
                                 $time, expData, dataOut);
                    end
                    // a word ack on a long or high cycle means a 16-bit port, so the low half follows
                    if (lane == LANE_LOW) begin
                        void'(wordQ.pop_front());
                        expAddr = expAddr + 32'd2;
                        lane = LANE_HIGH;
                    end else if (ackLong) begin
                        void'(wordQ.pop_front());
                        expAddr = expAddr + 32'd4;
                        lane = LANE_LONG;
                    end else begin
                        expAddr = expAddr + 32'd2;
                        lane = LANE_LOW;
                    end
                end
            end
            if (busReq && !reqQ) begin
                reqs++;
                if (!enaQ || prevPending == 0) begin
                    errs++;
                    $display("%0d ns: bus requested without enable or without data", $time);
                end
            end
            if (done) begin
                dones++;
                if (wordQ.size() != 0) begin
                    errs++;
                    $display("%0d ns: done pulsed while words were still waiting", $time);
                end
            end
            if (devWrite && !fifoFull) wordQ.push_back(devData);
            if (dmaEna && !enaQ) begin
                expAddr = startAddr; // a new transfer starts long at the programmed address
                lane = LANE_LONG;
            end
            prevPending = wordQ.size();
            enaQ      <= dmaEna;
            reqQ      <= busReq;
            errCount  <= errs;
            pending   <= wordQ.size();
            reqCount  <= reqs;
            doneCount <= dones;
            ackCount  <= acks;
        end
    end

endmodule

// ==== dv/tbTop.sv ====
// testbench top for the DMA channel, drives the device side and acts as the bus slave
`timescale 1ns/1ps

module tbTop;

    localparam int WAIT_LIMIT = 3000; // cycles any single wait may take

    logic        CLK90, nRESET, dmaEna, flush, devWrite, busGrant, ackLong, ackWord;
    logic [31:0] startAddr, devData;
    logic        fifoFull, busReq, busAck, addrStrobe, dataStrobe, done;
    logic [31:0] addr, dataOut, rngState, rndTmp;
    int          errCount, pending, reqCount, doneCount, ackCount;
    int          sizeMode; // 0 long port, 1 word port, 2 random per cycle
    int          localErr, passCount, failCount, grantWait, ackWait, errStart, mark;
    bit          grantArmed, ackArmed, useWord;

    dmaTop #(.FIFO_DEPTH(8)) dut0 (.*);

    dmaMonitor mon0 (.*);

    bind dmaTop dma_checker chk0 (
        .CLK90(CLK90), .nRESET(nRESET), .addrStrobe(addrStrobe), .busAck(busAck),
        .ackLong(ackLong), .ackWord(ackWord), .devWrite(devWrite), .fifoFull(fifoFull),
        .done(done)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x;
        y ^= y << 13;
        y ^= y >> 17;
        y ^= y << 5;
        return y;
    endfunction

    function logic [31:0] nextRand();
        rngState = xorshift(rngState);
        return rngState;
    endfunction

    // failures from the monitor, the bound assertions and the checks in this module
    function automatic int totalErrors();
        return errCount + localErr + dut0.chk0.violations;
    endfunction

    initial begin
        CLK90 = 1'b0;
        forever #50 CLK90 = ~CLK90;
    end

    // bus slave with random grant delay and wait states
    always @(posedge CLK90) begin
        if (busAck) begin
            busGrant   <= 1'b0;
            grantArmed <= 1'b0;
        end else if (busReq && !busGrant) begin
            if (!grantArmed) begin
                grantWait  <= int'(nextRand() % 32'd6);
                grantArmed <= 1'b1;
            end else if (grantWait == 0) busGrant <= 1'b1;
            else grantWait <= grantWait - 1;
        end
        if (!addrStrobe) begin
            {ackLong, ackWord, ackArmed} <= '0;
        end else if (!ackLong && !ackWord) begin
            if (!ackArmed) begin
                ackWait  <= int'(nextRand() % 32'd4);
                ackArmed <= 1'b1;
            end else if (ackWait == 0) begin
                useWord = (sizeMode == 1) || (sizeMode == 2 && nextRand() % 32'd2 == 0);
                ackWord <= useWord;
                ackLong <= !useWord;
            end else ackWait <= ackWait - 1;
        end
    end

    task automatic stopOnTimeout(input string what);
        $display("timeout while waiting for %s", what);
        $display("SOME TESTS FAILED");
        $finish;
    endtask

    task automatic checkValue(input string sig, input int expVal, input int actVal);
        if (expVal !== actVal) begin
            localErr++;
            $display("Fail at %0d ns: %s expected %0d got %0d", $time, sig, expVal, actVal);
        end
    endtask

    // one device write after a random gap, never into a full FIFO
    task automatic pushWord();
        int gap;
        int waited;
        gap = int'(nextRand() % 32'd4);
        waited = 0;
        repeat (gap) @(posedge CLK90);
        @(posedge CLK90);
        while (fifoFull) begin
            waited++;
            if (waited > WAIT_LIMIT) stopOnTimeout("the FIFO to leave full");
            @(posedge CLK90);
        end
        devWrite <= 1'b1;
        devData  <= nextRand();
        @(posedge CLK90);
        devWrite <= 1'b0;
    endtask

    task automatic waitDrained();
        int waited;
        waited = 0;
        @(posedge CLK90);
        while (pending != 0 || busAck || busReq) begin
            waited++;
            if (waited > WAIT_LIMIT) stopOnTimeout("the FIFO to drain and the bus to be released");
            @(posedge CLK90);
        end
        repeat (3) @(posedge CLK90); // let the FSM settle back into idle
    endtask

    task automatic startChannel();
        @(posedge CLK90);
        rndTmp = nextRand();
        startAddr <= {rndTmp[31:2], 2'b00};
        @(posedge CLK90);
        dmaEna <= 1'b1;
    endtask

    task automatic stopChannel();
        @(posedge CLK90);
        dmaEna <= 1'b0;
    endtask

    task automatic runBurst(input int words, input int mode);
        sizeMode = mode;
        mark = ackCount;
        startChannel();
        repeat (words) pushWord();
        waitDrained();
        stopChannel();
    endtask

    task automatic report(input string name);
        int errs;
        errs = totalErrors() - errStart;
        if (errs == 0) begin
            passCount++;
            $display("test %s: passed", name);
        end else begin
            failCount++;
            $display("test %s: failed with %0d errors", name, errs);
        end
        errStart = totalErrors();
    endtask

    initial begin
        int waited;
        rngState = 32'hc286_a4c8;
        {nRESET, dmaEna, flush, devWrite, busGrant, ackLong, ackWord} = '0;
        {startAddr, devData, sizeMode, localErr, passCount, failCount, errStart} = '0;
        {grantWait, ackWait, grantArmed, ackArmed} = '0;
        repeat (2) @(posedge CLK90);
        nRESET <= 1'b1;

        runBurst(20, 0);
        checkValue("long acknowledges", 20, ackCount - mark);
        report("1 32-bit port");
        runBurst(10, 1);
        checkValue("word acknowledges", 20, ackCount - mark);
        report("2 16-bit port");
        runBurst(24, 2);
        report("3 mixed sizing");

        // no request while disabled, one request per batch of data
        sizeMode = 0;
        mark = reqCount;
        repeat (3) pushWord();
        repeat (8) begin
            @(posedge CLK90);
            if (busReq) begin
                localErr++;
                $display("%0d ns: bus requested while the channel was disabled", $time);
            end
        end
        startChannel();
        waitDrained();
        repeat (2) pushWord();
        waitDrained();
        stopChannel();
        checkValue("busReq rises", 2, reqCount - mark);
        report("4 bus ownership");

        mark = doneCount;
        repeat (8) pushWord();
        @(posedge CLK90);
        checkValue("fifoFull", 1, int'(fifoFull));
        startChannel();
        @(posedge CLK90);
        flush <= 1'b1;
        @(posedge CLK90);
        flush <= 1'b0;
        waitDrained();
        waited = 0;
        while (doneCount == mark) begin
            waited++;
            if (waited > WAIT_LIMIT) stopOnTimeout("done after the flush");
            @(posedge CLK90);
        end
        repeat (4) @(posedge CLK90);
        checkValue("done pulses", 1, doneCount - mark);
        stopChannel();
        report("5 flush and full");

        $display("tests passed %0d, failed %0d", passCount, failCount);
        if (failCount == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
common/dmaPkg.sv
common/fifoIf.sv
common/bridgeIf.sv
hw/dmaFifo/dmaFifo.sv
hw/cpuSm/cpuSm.sv
hw/busBridge.sv
hw/dmaTop.sv
dv/dma_checker.sv
dv/dmaMonitor.sv
dv/tbTop.sv

// ==== run.sh ====
#!/usr/bin/env bash
# compiles the DMA testbench with Verilator, runs it and looks for the pass message

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tbTop -o simv
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

out=$(./obj_dir/simv)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "ALL TESTS PASSED"; then
    exit 0
fi
exit 1
